/* icache_geom_pkg.sv */
package icache_geom_pkg;

  // address and data width of the fetch path
  localparam int XLEN = 32;

  // 8 KB direct mapped, 128 lines of 64 bytes
  localparam int NUM_LINES = 128;
  localparam int LINE_WORDS = 16;

  // byte offset inside a line
  localparam int OFFSET_W = 6;

  // line index
  localparam int INDEX_W = 7;

  // tag is whatever is left above index and offset
  localparam int TAG_W = XLEN - INDEX_W - OFFSET_W;

  // word index inside a line
  localparam int WORD_IDX_W = 4;

  // address field positions
  // tag | index | word | byte
  localparam int INDEX_LSB = OFFSET_W;
  localparam int TAG_LSB = OFFSET_W + INDEX_W;

  // low two bits pick the byte inside a word
  localparam int WORD_LSB = 2;

  // halfword granule for compressed instructions
  localparam int HALF_W = 16;

  // last word of a line, also the last beat of a refill
  localparam logic [WORD_IDX_W-1:0] LAST_WORD_IDX = WORD_IDX_W'(LINE_WORDS - 1);

endpackage

/* icache_bus_pkg.sv */
package icache_bus_pkg;

  // width of the burst length field on the memory bus
  localparam int RLEN_W = 8;

  // length code is beats minus one
  // full line refill, 16 beats
  localparam logic [RLEN_W-1:0] BURST_LEN_LINE = 8'd15;

  // single word, uncached read
  localparam logic [RLEN_W-1:0] BURST_LEN_SINGLE = 8'd0;

  // uncached space is picked by the top address nibble
  localparam int REGION_W = 4;
  localparam logic [REGION_W-1:0] UNCACHE_REGION = 4'hA;

  // fetch controller states
  // IDLE          waits for a fetch request
  // LOOKUP        tag compare, hit returns data in this cycle
  // REFILL        line burst from memory, then back to LOOKUP
  // UNCACHED      single beat read, word is not stored
  // UNCACHED_DONE hands the latched word to the cpu
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED,
    UNCACHED_DONE
  } fetch_state_e;

endpackage

/* icache_line_store.sv */
`timescale 1ns/1ps

module icache_line_store (
  input  logic                                clk,
  input  logic                                rst,
  // lookup address, also selects the line for writes
  input  logic [icache_geom_pkg::XLEN-1:0]       look_addr_i,
  // refill writes
  input  logic                                fill_we_i,
  input  logic [icache_geom_pkg::WORD_IDX_W-1:0] fill_word_idx_i,
  input  logic [icache_geom_pkg::XLEN-1:0]       fill_data_i,
  input  logic                                tag_we_i,
  // lookup results
  output logic                                hit_o,
  output logic [icache_geom_pkg::XLEN-1:0]       word_lo_o,
  output logic [icache_geom_pkg::XLEN-1:0]       word_hi_o
);

  // one valid bit per line
  logic [icache_geom_pkg::NUM_LINES-1:0] valid_q;

  // tag array
  logic [icache_geom_pkg::TAG_W-1:0] tag_mem [icache_geom_pkg::NUM_LINES];

  // data array, line by word
  logic [icache_geom_pkg::XLEN-1:0]
    data_mem [icache_geom_pkg::NUM_LINES][icache_geom_pkg::LINE_WORDS];

  logic [icache_geom_pkg::INDEX_W-1:0]    look_idx;
  logic [icache_geom_pkg::TAG_W-1:0]      look_tag;
  logic [icache_geom_pkg::WORD_IDX_W-1:0] look_word;
  logic [icache_geom_pkg::WORD_IDX_W-1:0] next_word;

  // split the lookup address
  assign look_tag  = look_addr_i[icache_geom_pkg::XLEN-1:icache_geom_pkg::TAG_LSB];
  assign look_idx  = look_addr_i[icache_geom_pkg::TAG_LSB-1:icache_geom_pkg::INDEX_LSB];
  assign look_word = look_addr_i[icache_geom_pkg::OFFSET_W-1:icache_geom_pkg::WORD_LSB];

  // wraps at the line end, masked below
  assign next_word = look_word + 1'b1;

  // valid bits clear on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      valid_q[look_idx] <= 1'b1;
    end
  end

  // tag and data writes
  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_mem[look_idx] <= look_tag;
    end
    if (fill_we_i) begin
      data_mem[look_idx][fill_word_idx_i] <= fill_data_i;
    end
  end

  // direct mapped compare
  assign hit_o = valid_q[look_idx] && (tag_mem[look_idx] == look_tag);

  // word holding the offset
  assign word_lo_o = data_mem[look_idx][look_word];

  // following word in the same line
  // nothing past the last word, no cross-line fetch
  assign word_hi_o = (look_word == icache_geom_pkg::LAST_WORD_IDX) ? '0
                     : data_mem[look_idx][next_word];

endmodule

/* icache_inst_align.sv */
`timescale 1ns/1ps

module icache_inst_align (
  // byte offset of the fetch inside its line
  input  logic [icache_geom_pkg::OFFSET_W-1:0] look_offset_i,
  // word at the offset and the one after it
  input  logic [icache_geom_pkg::XLEN-1:0]     word_lo_i,
  input  logic [icache_geom_pkg::XLEN-1:0]     word_hi_i,
  // uncached bypass
  input  logic [icache_geom_pkg::XLEN-1:0]     uncache_word_i,
  input  logic                              uncache_sel_i,
  output logic [icache_geom_pkg::XLEN-1:0]     fetch_data_o
);

  logic                                 upper_half;
  logic [icache_geom_pkg::HALF_W-1:0]   cur_half;
  logic [icache_geom_pkg::HALF_W-1:0]   next_half;
  logic                                 is_full;
  logic [icache_geom_pkg::XLEN-1:0]     cached_inst;

  // bit 1 picks the halfword inside the word
  assign upper_half = look_offset_i[1];

  assign cur_half = upper_half ? word_lo_i[icache_geom_pkg::XLEN-1:icache_geom_pkg::HALF_W]
                    : word_lo_i[icache_geom_pkg::HALF_W-1:0];

  // upper half of the pair sits in the next word when crossing
  // word_hi is zero past the last word, so offset 62 pairs with zero
  always_comb begin
    if (upper_half) begin
      next_half = word_hi_i[icache_geom_pkg::HALF_W-1:0];
    end else begin
      next_half = word_lo_i[icache_geom_pkg::XLEN-1:icache_geom_pkg::HALF_W];
    end
  end

  // 2'b11 in the low bits marks a 32-bit encoding
  assign is_full = (cur_half[1:0] == 2'b11);

  // compressed ones come out zero extended
  assign cached_inst = is_full ? {next_half, cur_half}
                       : {{(icache_geom_pkg::XLEN - icache_geom_pkg::HALF_W){1'b0}}, cur_half};

  // uncached word passes untouched
  assign fetch_data_o = uncache_sel_i ? uncache_word_i : cached_inst;

endmodule

/* icache_fetch_ctrl.sv */
`timescale 1ns/1ps

module icache_fetch_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  // cpu side
  input  logic [icache_geom_pkg::XLEN-1:0]       fetch_addr_i,
  input  logic                                fetch_valid_i,
  output logic                                fetch_ready_o,
  // line store
  input  logic                                hit_i,
  output logic [icache_geom_pkg::XLEN-1:0]       look_addr_o,
  output logic                                fill_we_o,
  output logic [icache_geom_pkg::WORD_IDX_W-1:0] fill_word_idx_o,
  output logic [icache_geom_pkg::XLEN-1:0]       fill_data_o,
  output logic                                tag_we_o,
  // aligner
  output logic [icache_geom_pkg::XLEN-1:0]       uncache_word_o,
  output logic                                uncache_sel_o,
  // memory side
  input  logic                                mem_beat_i,
  input  logic [icache_geom_pkg::XLEN-1:0]       mem_rdata_i,
  output logic                                mem_req_o,
  output logic [icache_geom_pkg::XLEN-1:0]       mem_addr_o,
  output logic [icache_bus_pkg::RLEN_W-1:0]      mem_rlen_o
);

  icache_bus_pkg::fetch_state_e state_q;

  // fetch address held for the whole request
  logic [icache_geom_pkg::XLEN-1:0] addr_q;

  // beat counter, doubles as fill word index
  logic [icache_geom_pkg::WORD_IDX_W-1:0] beat_cnt_q;

  logic                                 mem_req_q;
  logic [icache_geom_pkg::XLEN-1:0]     mem_addr_q;
  logic [icache_bus_pkg::RLEN_W-1:0]    mem_rlen_q;
  logic [icache_geom_pkg::XLEN-1:0]     uncache_word_q;

  logic is_uncached;
  logic beat;
  logic last_beat;

  // uncached when the top nibble hits the io region
  assign is_uncached = (addr_q[icache_geom_pkg::XLEN-1 -: icache_bus_pkg::REGION_W]
                        == icache_bus_pkg::UNCACHE_REGION);

  // one beat per cycle with request and strobe both high
  assign beat      = mem_req_q && mem_beat_i;
  assign last_beat = (beat_cnt_q == icache_geom_pkg::LAST_WORD_IDX);

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= icache_bus_pkg::IDLE;
      mem_req_q  <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        icache_bus_pkg::IDLE: begin
          if (fetch_valid_i) begin
            state_q <= icache_bus_pkg::LOOKUP;
          end
        end
        icache_bus_pkg::LOOKUP: begin
          // io space bypasses the arrays even if a tag looks equal
          if (is_uncached) begin
            state_q   <= icache_bus_pkg::UNCACHED;
            mem_req_q <= 1'b1;
          end else if (!hit_i) begin
            state_q    <= icache_bus_pkg::REFILL;
            mem_req_q  <= 1'b1;
            beat_cnt_q <= '0;
          end else begin
            state_q <= icache_bus_pkg::IDLE;
          end
        end
        icache_bus_pkg::REFILL: begin
          if (beat) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            // tag goes in with the last word, lookup then hits
            if (last_beat) begin
              mem_req_q <= 1'b0;
              state_q   <= icache_bus_pkg::LOOKUP;
            end
          end
        end
        icache_bus_pkg::UNCACHED: begin
          if (beat) begin
            mem_req_q <= 1'b0;
            state_q   <= icache_bus_pkg::UNCACHED_DONE;
          end
        end
        icache_bus_pkg::UNCACHED_DONE: begin
          state_q <= icache_bus_pkg::IDLE;
        end
        default: begin
          state_q <= icache_bus_pkg::IDLE;
        end
      endcase
    end
  end

  // address and data payload
  always_ff @(posedge clk) begin
    // capture on acceptance
    if (state_q == icache_bus_pkg::IDLE && fetch_valid_i) begin
      addr_q <= fetch_addr_i;
    end
    // bus address and length set up for the next cycle
    if (state_q == icache_bus_pkg::LOOKUP) begin
      if (is_uncached) begin
        // exact address, one beat
        mem_addr_q <= addr_q;
        mem_rlen_q <= icache_bus_pkg::BURST_LEN_SINGLE;
      end else begin
        // line aligned burst
        mem_addr_q <= {addr_q[icache_geom_pkg::XLEN-1:icache_geom_pkg::OFFSET_W],
                       {icache_geom_pkg::OFFSET_W{1'b0}}};
        mem_rlen_q <= icache_bus_pkg::BURST_LEN_LINE;
      end
    end
    if (state_q == icache_bus_pkg::UNCACHED && beat) begin
      uncache_word_q <= mem_rdata_i;
    end
  end

  // store writes ride on each refill beat
  assign fill_we_o       = beat && (state_q == icache_bus_pkg::REFILL);
  assign fill_word_idx_o = beat_cnt_q;
  assign fill_data_o     = mem_rdata_i;
  assign tag_we_o        = fill_we_o && last_beat;

  assign look_addr_o    = addr_q;
  assign uncache_word_o = uncache_word_q;
  assign uncache_sel_o  = (state_q == icache_bus_pkg::UNCACHED_DONE);

  // ready on a cached hit or on the uncached hand-off cycle
  assign fetch_ready_o = ((state_q == icache_bus_pkg::LOOKUP) && hit_i && !is_uncached)
                         || uncache_sel_o;

  assign mem_req_o  = mem_req_q;
  assign mem_addr_o = mem_addr_q;
  assign mem_rlen_o = mem_rlen_q;

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top (
  input  logic                           clk,
  input  logic                           rst,
  // cpu fetch port
  input  logic [icache_geom_pkg::XLEN-1:0]  fetch_addr_i,
  input  logic                           fetch_valid_i,
  output logic [icache_geom_pkg::XLEN-1:0]  fetch_data_o,
  output logic                           fetch_ready_o,
  // memory read port
  output logic                           mem_req_o,
  output logic [icache_geom_pkg::XLEN-1:0]  mem_addr_o,
  output logic [icache_bus_pkg::RLEN_W-1:0] mem_rlen_o,
  input  logic                           mem_beat_i,
  input  logic [icache_geom_pkg::XLEN-1:0]  mem_rdata_i
);

  // controller to store and aligner
  logic [icache_geom_pkg::XLEN-1:0]       look_addr;
  logic                                fill_we;
  logic [icache_geom_pkg::WORD_IDX_W-1:0] fill_word_idx;
  logic [icache_geom_pkg::XLEN-1:0]       fill_data;
  logic                                tag_we;
  logic [icache_geom_pkg::XLEN-1:0]       uncache_word;
  logic                                uncache_sel;

  // store results
  logic                                hit;
  logic [icache_geom_pkg::XLEN-1:0]       word_lo;
  logic [icache_geom_pkg::XLEN-1:0]       word_hi;

  icache_fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_ready_o   (fetch_ready_o),
    .hit_i           (hit),
    .look_addr_o     (look_addr),
    .fill_we_o       (fill_we),
    .fill_word_idx_o (fill_word_idx),
    .fill_data_o     (fill_data),
    .tag_we_o        (tag_we),
    .uncache_word_o  (uncache_word),
    .uncache_sel_o   (uncache_sel),
    .mem_beat_i      (mem_beat_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_rlen_o      (mem_rlen_o)
  );

  icache_line_store u_line_store (
    .clk             (clk),
    .rst             (rst),
    .look_addr_i     (look_addr),
    .fill_we_i       (fill_we),
    .fill_word_idx_i (fill_word_idx),
    .fill_data_i     (fill_data),
    .tag_we_i        (tag_we),
    .hit_o           (hit),
    .word_lo_o       (word_lo),
    .word_hi_o       (word_hi)
  );

  // aligner only needs the in-line offset
  icache_inst_align u_inst_align (
    .look_offset_i  (look_addr[icache_geom_pkg::OFFSET_W-1:0]),
    .word_lo_i      (word_lo),
    .word_hi_i      (word_hi),
    .uncache_word_i (uncache_word),
    .uncache_sel_i  (uncache_sel),
    .fetch_data_o   (fetch_data_o)
  );

endmodule

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

  localparam int CLK_HALF_NS = 50;
  localparam int CLK_NS = 2 * CLK_HALF_NS;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_REQ = 300;
  // 16 beats with up to 3 idle cycles each, plus lookup and handshake cycles
  localparam int REQ_BOUND_CYCLES = 100;
  localparam int WATCHDOG_NS = (NUM_REQ * REQ_BOUND_CYCLES + RESET_CYCLES + 20) * CLK_NS;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] fetch_addr_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_data_o;
  logic        fetch_ready_o;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic [7:0]  mem_rlen_o;
  logic        mem_beat_i = 1'b0;
  logic [31:0] mem_rdata_i = 32'h0;

  int seed = 84;
  int gap_seed = 84;
  int data_errors = 0;
  int latency_errors = 0;
  int bus_errors = 0;

  // reference model of the tag side
  bit          ref_valid [0:127];
  logic [18:0] ref_tag [0:127];

  icache_top uut (
    .clk           (clk),
    .rst           (rst),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_o  (fetch_data_o),
    .fetch_ready_o (fetch_ready_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_rlen_o    (mem_rlen_o),
    .mem_beat_i    (mem_beat_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  always #(CLK_HALF_NS) clk = ~clk;

  // memory content, a fixed hash of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]};
    return (w * 32'h9E3779B1) ^ {w[15:0], w[31:16]} ^ 32'h6A09E667;
  endfunction

  // halfword at a byte offset inside the line at base
  function automatic logic [15:0] half_at(input logic [31:0] base, input logic [5:0] off);
    logic [31:0] w;
    w = mem_word(base | {26'h0, off[5:2], 2'b00});
    return off[1] ? w[31:16] : w[15:0];
  endfunction

  // rvc length rule, nothing follows offset 62
  function automatic logic [31:0] expected_inst(input logic [31:0] addr);
    logic [31:0] base;
    logic [15:0] cur;
    logic [15:0] nxt;
    base = {addr[31:6], 6'h00};
    cur = half_at(base, addr[5:0]);
    nxt = (addr[5:0] == 6'd62) ? 16'h0 : half_at(base, addr[5:0] + 6'd2);
    return (cur[1:0] == 2'b11) ? {nxt, cur} : {16'h0, cur};
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] addr,
                               input logic [31:0] expv, input logic [31:0] actv);
    $display("FAILED %s at addr %h: expected %h, actual %h", name, addr, expv, actv);
  endtask

  // memory model, holds each beat until taken, then a random gap of 0 to 3
  int beat_num = 0;
  int gap_left = 0;
  always @(posedge clk) begin
    if (rst) begin
      mem_beat_i <= 1'b0;
      beat_num = 0;
      gap_left = 0;
    end else begin
      if (mem_req_o && mem_beat_i) begin
        beat_num = beat_num + 1;
        gap_left = $random(gap_seed) & 3;
      end
      if (!mem_req_o) begin
        beat_num = 0;
      end
      if (mem_req_o && beat_num <= int'(mem_rlen_o) && gap_left == 0) begin
        mem_beat_i  <= 1'b1;
        mem_rdata_i <= mem_word(mem_addr_o + 32'(4 * beat_num));
      end else begin
        mem_beat_i  <= 1'b0;
        mem_rdata_i <= 32'hDEAD_BEEF;
        if (gap_left > 0) begin
          gap_left = gap_left - 1;
        end
      end
    end
  end

  // one fetch with checks against the model
  task automatic run_fetch(input logic [31:0] addr);
    logic        uncached;
    logic        expect_hit;
    logic [6:0]  idx;
    logic [18:0] tag;
    logic [31:0] exp_data;
    logic [31:0] got;
    logic        req_seen;
    logic [31:0] req_addr;
    logic [7:0]  req_len;
    int          cycles;
    int          req_cycle;
    uncached = (addr[31:28] == 4'hA);
    idx = addr[12:6];
    tag = addr[31:13];
    expect_hit = !uncached && ref_valid[idx] && (ref_tag[idx] == tag);
    exp_data = uncached ? mem_word({addr[31:2], 2'b00}) : expected_inst(addr);
    req_seen = 1'b0;
    req_addr = 32'h0;
    req_len = 8'h0;
    cycles = 0;
    req_cycle = 0;
    @(posedge clk);
    fetch_addr_i  <= addr;
    fetch_valid_i <= 1'b1;
    // sample on the falling edge, away from the drive edge
    do begin
      @(negedge clk);
      cycles++;
      if (mem_req_o && !req_seen) begin
        req_seen = 1'b1;
        req_cycle = cycles;
        req_addr = mem_addr_o;
        req_len = mem_rlen_o;
      end
    end while (!fetch_ready_o);
    got = fetch_data_o;
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    if (cycles < 2) begin
      $display("fetch_ready_o rose before the request at %h was accepted", addr);
      latency_errors++;
    end
    if (expect_hit) begin
      // accept edge, then ready in the lookup cycle
      if (cycles != 2) begin
        show_mismatch("hit_latency", addr, 32'd2, 32'(cycles));
        latency_errors++;
      end
      if (req_seen) begin
        $display("memory request issued on a hit at %h", addr);
        bus_errors++;
      end
    end else if (!req_seen) begin
      $display("no memory request for the uncached or missing fetch at %h", addr);
      bus_errors++;
    end else if (uncached) begin
      if (req_len != 8'd0) begin
        show_mismatch("uncached_len", addr, 32'd0, {24'h0, req_len});
        bus_errors++;
      end
      if (req_addr != addr) begin
        show_mismatch("uncached_addr", addr, addr, req_addr);
        bus_errors++;
      end
    end else begin
      // request rises in the cycle after the missing lookup
      if (req_cycle != 3) begin
        show_mismatch("miss_req_cycle", addr, 32'd3, 32'(req_cycle));
        latency_errors++;
      end
      if (req_len != 8'd15) begin
        show_mismatch("refill_len", addr, 32'd15, {24'h0, req_len});
        bus_errors++;
      end
      if (req_addr != {addr[31:6], 6'h00}) begin
        show_mismatch("refill_addr", addr, {addr[31:6], 6'h00}, req_addr);
        bus_errors++;
      end
    end
    if (got !== exp_data) begin
      show_mismatch("fetch_data", addr, exp_data, got);
      data_errors++;
    end
    if (!uncached) begin
      ref_valid[idx] = 1'b1;
      ref_tag[idx] = tag;
    end
  endtask

  // small tag and index sets, so lines hit and conflict often
  function automatic logic [31:0] cached_addr(input logic [1:0] tsel, input logic [1:0] isel,
                                              input logic [5:0] off);
    return {4'h1, 13'h0, tsel, isel, 5'h0B, off};
  endfunction

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the DUT stopped answering fetch requests");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] addr;
    logic [31:0] last_unc;
    logic [5:0]  off;
    int          total;
    rst = 1'b1;
    fetch_addr_i = 32'h0;
    fetch_valid_i = 1'b0;
    last_unc = 32'hA000_0000;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (fetch_ready_o || mem_req_o) begin
      $display("fetch_ready_o or mem_req_o high right after reset");
      bus_errors++;
    end
    // cold cache, first cacheable fetch must refill
    run_fetch(cached_addr(2'd0, 2'd0, 6'd0));
    for (int n = 0; n < NUM_REQ; n++) begin
      r = $random(seed);
      r2 = $random(seed);
      // offset mix, 62, word crossing, or any halfword
      case (r[4:3])
        2'd0: off = 6'd62;
        2'd1: off = {r[8:5], 2'b10};
        default: off = {r[9:5], 1'b0};
      endcase
      case (r[2:0])
        3'd0: begin
          addr = {4'hA, r2[27:1], 1'b0};
          last_unc = addr;
        end
        // same uncached address again, must go to memory again
        3'd1: addr = last_unc;
        default: addr = cached_addr(r[12:11], r[14:13], off);
      endcase
      run_fetch(addr);
    end
    total = data_errors + latency_errors + bus_errors;
    $display("errors: data %0d, latency %0d, bus %0d, total %0d",
             data_errors, latency_errors, bus_errors, total);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
icache_geom_pkg.sv
icache_bus_pkg.sv
icache_line_store.sv
icache_inst_align.sv
icache_fetch_ctrl.sv
icache_top.sv
tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module tb_icache \
  -o sim_icache
./obj_dir/sim_icache > sim.log
cat sim.log
if grep -q "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
